//--- rx_pcs_pkg.sv
`default_nettype none

package rx_pcs_pkg;

    // transceiver and xgmii word size
    localparam int DATA_WIDTH = 32;
    localparam int DATA_NBYTES = DATA_WIDTH / 8;

    // sync headers, as seen in the 2-bit header field
    localparam logic [1:0] SYNC_DATA = 2'b01;
    localparam logic [1:0] SYNC_CTRL = 2'b10;

    // block type field, first payload byte of a control block
    localparam logic [7:0] BT_CTRL = 8'h1e;
    localparam logic [7:0] BT_START = 8'h78;
    localparam logic [7:0] BT_TERM0 = 8'h87;
    localparam logic [7:0] BT_TERM1 = 8'h99;
    localparam logic [7:0] BT_TERM2 = 8'haa;
    localparam logic [7:0] BT_TERM3 = 8'hb4;
    localparam logic [7:0] BT_TERM4 = 8'hcc;
    localparam logic [7:0] BT_TERM5 = 8'hd2;
    localparam logic [7:0] BT_TERM6 = 8'he1;
    localparam logic [7:0] BT_TERM7 = 8'hff;

    // xgmii control characters
    localparam logic [7:0] RS_IDLE = 8'h07;
    localparam logic [7:0] RS_START = 8'hfb;
    localparam logic [7:0] RS_TERM = 8'hfd;
    localparam logic [7:0] RS_ERROR = 8'hfe;

    // 7-bit pcs control codes
    localparam logic [6:0] PCS_IDLE = 7'h00;
    localparam logic [6:0] PCS_ERROR = 7'h1e;

    // descrambler polynomial x^58 + x^39 + 1
    localparam int SCR_LEN = 58;
    localparam int SCR_TAP = 39;

    // block lock thresholds
    localparam int LOCK_GOOD_COUNT = 64;
    localparam int LOCK_BAD_LIMIT = 16;
    localparam int LOCK_WINDOW = 64;
    localparam int SLIP_WAIT = 4;

    // counter widths for the lock fsm
    localparam int GOOD_CNT_W = $clog2(LOCK_GOOD_COUNT);
    localparam int BAD_CNT_W = $clog2(LOCK_BAD_LIMIT);
    localparam int WIN_CNT_W = $clog2(LOCK_WINDOW);
    localparam int WAIT_CNT_W = $clog2(SLIP_WAIT + 1);

    // one gearbox word
    // header and header_valid only mean something on the first word of a block
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0] header;
        logic data_valid;
        logic header_valid;
    } xver_word_t;

    // one xgmii word, lane 0 in the low byte
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DATA_NBYTES-1:0] ctl;
        logic valid;
    } xgmii_word_t;

endpackage

`default_nettype wire

//--- block_lock.sv
`timescale 1ns/1ps
`default_nettype none

module block_lock (
    input wire i_clk,
    input wire i_reset,
    input wire [1:0] i_header,
    input wire i_header_valid,
    output logic o_slip,
    output logic o_block_lock
);

    logic hdr_ok;
    logic good_done;
    logic bad_done;
    logic win_done;
    logic [rx_pcs_pkg::GOOD_CNT_W-1:0] good_cnt;
    logic [rx_pcs_pkg::BAD_CNT_W-1:0] bad_cnt;
    logic [rx_pcs_pkg::WIN_CNT_W-1:0] win_cnt;
    logic [rx_pcs_pkg::WAIT_CNT_W-1:0] wait_cnt;

    // only 01 and 10 are legal sync headers
    assign hdr_ok = (i_header == rx_pcs_pkg::SYNC_DATA) || (i_header == rx_pcs_pkg::SYNC_CTRL);

    // last good header before lock
    assign good_done = good_cnt == rx_pcs_pkg::GOOD_CNT_W'(rx_pcs_pkg::LOCK_GOOD_COUNT - 1);
    // this bad header reaches the limit
    assign bad_done = bad_cnt == rx_pcs_pkg::BAD_CNT_W'(rx_pcs_pkg::LOCK_BAD_LIMIT - 1);
    // last header of the window
    assign win_done = win_cnt == rx_pcs_pkg::WIN_CNT_W'(rx_pcs_pkg::LOCK_WINDOW - 1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_slip <= 1'b0;
            o_block_lock <= 1'b0;
            good_cnt <= '0;
            bad_cnt <= '0;
            win_cnt <= '0;
            wait_cnt <= '0;
        end else begin
            // slip is a one cycle pulse
            o_slip <= 1'b0;
            if (i_header_valid) begin
                if (wait_cnt != '0) begin
                    // gearbox still settling after a slip
                    wait_cnt <= wait_cnt - 1'b1;
                end else if (!o_block_lock) begin
                    // hunting
                    if (!hdr_ok) begin
                        good_cnt <= '0;
                        o_slip <= 1'b1;
                        wait_cnt <= rx_pcs_pkg::WAIT_CNT_W'(rx_pcs_pkg::SLIP_WAIT);
                    end else if (good_done) begin
                        o_block_lock <= 1'b1;
                        good_cnt <= '0;
                        bad_cnt <= '0;
                        win_cnt <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end else if (!hdr_ok && bad_done) begin
                    // too many bad headers in this window, back to hunting
                    o_block_lock <= 1'b0;
                    o_slip <= 1'b1;
                    wait_cnt <= rx_pcs_pkg::WAIT_CNT_W'(rx_pcs_pkg::SLIP_WAIT);
                    good_cnt <= '0;
                end else if (win_done) begin
                    // new window starts clean
                    win_cnt <= '0;
                    bad_cnt <= '0;
                end else begin
                    win_cnt <= win_cnt + 1'b1;
                    if (!hdr_ok) begin
                        bad_cnt <= bad_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- descrambler.sv
`timescale 1ns/1ps
`default_nettype none

module descrambler (
    input wire i_clk,
    input wire i_reset,
    input wire rx_pcs_pkg::xver_word_t i_word,
    output rx_pcs_pkg::xver_word_t o_word
);

    // last SCR_LEN scrambled bits, newest at the top
    logic [rx_pcs_pkg::SCR_LEN-1:0] history;
    // history followed by the current word, bit i of the word at SCR_LEN + i
    logic [rx_pcs_pkg::SCR_LEN+rx_pcs_pkg::DATA_WIDTH-1:0] stream;
    logic [rx_pcs_pkg::DATA_WIDTH-1:0] plain;

    assign stream = {i_word.data, history};

    // each bit xor the bits 39 and 58 back in the received stream
    // taps inside the current word come straight from the input
    assign plain = i_word.data
        ^ stream[rx_pcs_pkg::SCR_LEN-rx_pcs_pkg::SCR_TAP +: rx_pcs_pkg::DATA_WIDTH]
        ^ stream[0 +: rx_pcs_pkg::DATA_WIDTH];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            history <= '0;
            o_word.data_valid <= 1'b0;
            o_word.header_valid <= 1'b0;
        end else begin
            // advance only on real words, hold through gaps
            if (i_word.data_valid) begin
                history <= stream[rx_pcs_pkg::DATA_WIDTH +: rx_pcs_pkg::SCR_LEN];
            end
            o_word.data_valid <= i_word.data_valid;
            o_word.header_valid <= i_word.header_valid;
        end
        // header is never scrambled
        o_word.data <= plain;
        o_word.header <= i_word.header;
    end

endmodule

`default_nettype wire

//--- decode_6466b.sv
`timescale 1ns/1ps
`default_nettype none

module decode_6466b (
    input wire i_clk,
    input wire i_reset,
    input wire rx_pcs_pkg::xver_word_t i_word,
    output rx_pcs_pkg::xgmii_word_t o_word
);

    // header and type of the block in flight
    logic [1:0] blk_hdr;
    logic [7:0] blk_type;
    logic [1:0] cur_hdr;
    logic [7:0] cur_type;
    logic second;
    logic [rx_pcs_pkg::DATA_WIDTH-1:0] dec_data;
    logic [rx_pcs_pkg::DATA_NBYTES-1:0] dec_ctl;

    // 7-bit control code to xgmii character
    function automatic logic [7:0] ctrl_char(input logic [6:0] code);
        logic [7:0] ch;
        case (code)
            rx_pcs_pkg::PCS_IDLE: ch = rx_pcs_pkg::RS_IDLE;
            rx_pcs_pkg::PCS_ERROR: ch = rx_pcs_pkg::RS_ERROR;
            // reserved codes
            default: ch = rx_pcs_pkg::RS_ERROR;
        endcase
        return ch;
    endfunction

    // terminate types, returns {found, lane of the terminate}
    function automatic logic [3:0] term_pos(input logic [7:0] btype);
        logic [3:0] pos;
        case (btype)
            rx_pcs_pkg::BT_TERM0: pos = {1'b1, 3'd0};
            rx_pcs_pkg::BT_TERM1: pos = {1'b1, 3'd1};
            rx_pcs_pkg::BT_TERM2: pos = {1'b1, 3'd2};
            rx_pcs_pkg::BT_TERM3: pos = {1'b1, 3'd3};
            rx_pcs_pkg::BT_TERM4: pos = {1'b1, 3'd4};
            rx_pcs_pkg::BT_TERM5: pos = {1'b1, 3'd5};
            rx_pcs_pkg::BT_TERM6: pos = {1'b1, 3'd6};
            rx_pcs_pkg::BT_TERM7: pos = {1'b1, 3'd7};
            default: pos = 4'h0;
        endcase
        return pos;
    endfunction

    // one lane of the block, lane 0..7, returns {ctl, character}
    function automatic logic [8:0] decode_lane(
        input logic [1:0] hdr,
        input logic [7:0] btype,
        input logic [2:0] lane,
        input logic [rx_pcs_pkg::DATA_WIDTH-1:0] word
    );
        logic [1:0] j;
        logic [3:0] term;
        logic [6:0] code;
        logic [8:0] res;
        j = lane[1:0];
        term = term_pos(btype);
        // control codes sit 7 bits apart after the type byte
        if (!lane[2]) begin
            if (j == 2'd3) begin
                // only the low 3 bits of code 3 are in word one
                // still enough to tell IDLE from ERROR
                code = {4'b0000, word[rx_pcs_pkg::DATA_WIDTH-1 -: 3]};
            end else begin
                code = word[8 + 7*j +: 7];
            end
        end else begin
            // codes 4..7 start 4 bits into word two
            code = word[4 + 7*j +: 7];
        end
        // bad header or unknown type
        res = {1'b1, rx_pcs_pkg::RS_ERROR};
        if (hdr == rx_pcs_pkg::SYNC_DATA) begin
            res = {1'b0, word[8*j +: 8]};
        end else if (hdr == rx_pcs_pkg::SYNC_CTRL) begin
            if (btype == rx_pcs_pkg::BT_CTRL) begin
                res = {1'b1, ctrl_char(code)};
            end else if (btype == rx_pcs_pkg::BT_START) begin
                // start replaces the type byte, data lanes line up with the words
                if (lane == 3'd0) begin
                    res = {1'b1, rx_pcs_pkg::RS_START};
                end else begin
                    res = {1'b0, word[8*j +: 8]};
                end
            end else if (term[3]) begin
                if (lane == term[2:0]) begin
                    res = {1'b1, rx_pcs_pkg::RS_TERM};
                end else if (lane > term[2:0]) begin
                    res = {1'b1, rx_pcs_pkg::RS_IDLE};
                end else if (lane != 3'd3) begin
                    // data byte n follows the type byte, one byte up
                    res = {1'b0, word[8*(j+1) +: 8]};
                end
                // D3 of T4..T7 only arrives with word two, flagged as error
            end
        end
        return res;
    endfunction

    // first word decodes from its own header, second from the latched one
    assign second = !i_word.header_valid;
    assign cur_hdr = i_word.header_valid ? i_word.header : blk_hdr;
    assign cur_type = i_word.header_valid ? i_word.data[7:0] : blk_type;

    always_comb begin
        for (int j = 0; j < rx_pcs_pkg::DATA_NBYTES; j++) begin
            {dec_ctl[j], dec_data[8*j +: 8]} =
                decode_lane(cur_hdr, cur_type, {second, 2'(j)}, i_word.data);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // second word without a first decodes as error
            blk_hdr <= 2'b00;
            o_word.valid <= 1'b0;
        end else begin
            if (i_word.header_valid) begin
                blk_hdr <= i_word.header;
            end
            o_word.valid <= i_word.data_valid;
        end
        if (i_word.header_valid) begin
            blk_type <= i_word.data[7:0];
        end
        // output holds through gaps
        if (i_word.data_valid) begin
            o_word.data <= dec_data;
            o_word.ctl <= dec_ctl;
        end
    end

endmodule

`default_nettype wire

//--- rx_pcs.sv
`timescale 1ns/1ps
`default_nettype none

module rx_pcs (
    input wire xver_rx_clk,
    input wire rx_reset,
    // from the external gearbox
    input wire rx_pcs_pkg::xver_word_t i_xver_rx,
    output logic o_xver_rx_gearbox_slip,
    output logic o_block_lock,
    // to the mac
    output rx_pcs_pkg::xgmii_word_t o_xgmii_rx,
    output logic [rx_pcs_pkg::DATA_NBYTES-1:0] o_term_loc
);

    rx_pcs_pkg::xver_word_t desc_word;
    rx_pcs_pkg::xgmii_word_t dec_word;
    logic [rx_pcs_pkg::DATA_NBYTES-1:0] term_mask;

    // sync header lock, drives the gearbox slip
    block_lock block_lock_i (
        .i_clk(xver_rx_clk),
        .i_reset(rx_reset),
        .i_header(i_xver_rx.header),
        .i_header_valid(i_xver_rx.header_valid),
        .o_slip(o_xver_rx_gearbox_slip),
        .o_block_lock(o_block_lock)
    );

    // one cycle, header and strobes ride along
    descrambler descrambler_i (
        .i_clk(xver_rx_clk),
        .i_reset(rx_reset),
        .i_word(i_xver_rx),
        .o_word(desc_word)
    );

    // one cycle, half a block per word
    decode_6466b decode_6466b_i (
        .i_clk(xver_rx_clk),
        .i_reset(rx_reset),
        .i_word(desc_word),
        .o_word(dec_word)
    );

    // terminate lane worked out here so the mac gets it registered
    always_comb begin
        for (int i = 0; i < rx_pcs_pkg::DATA_NBYTES; i++) begin
            term_mask[i] = dec_word.valid && dec_word.ctl[i]
                && (dec_word.data[8*i +: 8] == rx_pcs_pkg::RS_TERM);
        end
    end

    // output register, third pipeline stage
    always_ff @(posedge xver_rx_clk) begin
        if (rx_reset) begin
            o_xgmii_rx <= '0;
            o_term_loc <= '0;
        end else begin
            o_xgmii_rx <= dec_word;
            o_term_loc <= term_mask;
        end
    end

endmodule

`default_nettype wire

//--- rx_pcs_props.sv
`timescale 1ns/1ps
`default_nettype none

module rx_pcs_props (
    input wire i_clk,
    input wire i_reset,
    input wire i_slip,
    input wire i_block_lock,
    input wire rx_pcs_pkg::xgmii_word_t i_xgmii,
    input wire [rx_pcs_pkg::DATA_NBYTES-1:0] i_term_loc
);

    // every output cleared one cycle into reset
    reset_clears: assert property (@(posedge i_clk)
        i_reset |=> (i_xgmii == '0) && (i_term_loc == '0) && !i_slip && !i_block_lock)
        else $error("outputs not cleared after reset");

    // slip is a single cycle pulse
    slip_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_slip |=> !i_slip)
        else $error("gearbox slip held for two cycles");

    // one terminate per word at most
    term_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0(i_term_loc))
        else $error("more than one terminate lane flagged");

    term_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_term_loc != '0) |-> i_xgmii.valid)
        else $error("terminate mask set without valid");

endmodule

bind rx_pcs rx_pcs_props rx_pcs_props_i (
    .i_clk(xver_rx_clk),
    .i_reset(rx_reset),
    .i_slip(o_xver_rx_gearbox_slip),
    .i_block_lock(o_block_lock),
    .i_xgmii(o_xgmii_rx),
    .i_term_loc(o_term_loc)
);

`default_nettype wire

//--- rx_pcs_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_pcs_tb;

    // one expected xgmii word with its terminate mask
    typedef struct packed {
        logic [31:0] data;
        logic [3:0] ctl;
        logic [3:0] term;
    } exp_word_t;

    localparam int N_FRAMES = 24;
    // lock hunt, frames of at most seven blocks, then window padding and bad runs
    localparam int MAX_BLOCKS = 74 + N_FRAMES * 7 + 160;
    // two words per block with up to three gap cycles each, plus reset and checks
    localparam int TIMEOUT_CYCLES = MAX_BLOCKS * 8 + 300;
    localparam logic [7:0] TERM_TYPES [8] = '{
        rx_pcs_pkg::BT_TERM0, rx_pcs_pkg::BT_TERM1, rx_pcs_pkg::BT_TERM2, rx_pcs_pkg::BT_TERM3,
        rx_pcs_pkg::BT_TERM4, rx_pcs_pkg::BT_TERM5, rx_pcs_pkg::BT_TERM6, rx_pcs_pkg::BT_TERM7
    };
    // lane-4 start and ordered-set types, not decoded by this pcs
    localparam logic [7:0] BAD_TYPES [4] = '{8'h33, 8'h66, 8'h55, 8'h4b};

    logic xver_rx_clk;
    logic rx_reset;
    rx_pcs_pkg::xver_word_t i_xver_rx;
    logic o_xver_rx_gearbox_slip;
    logic o_block_lock;
    rx_pcs_pkg::xgmii_word_t o_xgmii_rx;
    logic [3:0] o_term_loc;

    logic [31:0] lfsr_state;
    // transmit scrambler, newest bit at index 0
    logic [57:0] scr_state;
    exp_word_t exp_q[$];
    int errors = 0;
    int checked = 0;
    int slips = 0;
    int hdr_count = 0;
    int lock_at = 0;
    int cycles;

    rx_pcs rx_pcs_i (
        .xver_rx_clk(xver_rx_clk),
        .rx_reset(rx_reset),
        .i_xver_rx(i_xver_rx),
        .o_xver_rx_gearbox_slip(o_xver_rx_gearbox_slip),
        .o_block_lock(o_block_lock),
        .o_xgmii_rx(o_xgmii_rx),
        .o_term_loc(o_term_loc)
    );

    initial begin
        xver_rx_clk = 1'b0;
        forever #5 xver_rx_clk = ~xver_rx_clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // x^58 + x^39 + 1, lsb first, feeds back the scrambled bit
    function automatic logic [31:0] scramble(input logic [31:0] d);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < 32; i++) begin
            s[i] = d[i] ^ scr_state[38] ^ scr_state[57];
            scr_state = {scr_state[56:0], s[i]};
        end
        return s;
    endfunction

    function automatic int term_lane(input logic [7:0] btype);
        int p;
        p = -1;
        for (int i = 0; i < 8; i++) begin
            if (btype == TERM_TYPES[i]) begin
                p = i;
            end
        end
        return p;
    endfunction

    // expected lanes 0..7 of a block as {ctl, data}, error unless a rule matches
    function automatic logic [71:0] ref_decode(input logic [1:0] hdr, input logic [63:0] pl);
        logic [7:0] ctl;
        logic [63:0] lanes;
        int tpos;
        ctl = 8'hff;
        lanes = {8{rx_pcs_pkg::RS_ERROR}};
        tpos = term_lane(pl[7:0]);
        if (hdr == rx_pcs_pkg::SYNC_DATA) begin
            ctl = 8'h00;
            lanes = pl;
        end else if (hdr == rx_pcs_pkg::SYNC_CTRL && pl[7:0] == rx_pcs_pkg::BT_CTRL) begin
            for (int n = 0; n < 8; n++) begin
                if (pl[8 + 7*n +: 7] == rx_pcs_pkg::PCS_IDLE) begin
                    lanes[8*n +: 8] = rx_pcs_pkg::RS_IDLE;
                end
            end
        end else if (hdr == rx_pcs_pkg::SYNC_CTRL && pl[7:0] == rx_pcs_pkg::BT_START) begin
            ctl = 8'h01;
            lanes = {pl[63:8], rx_pcs_pkg::RS_START};
        end else if (hdr == rx_pcs_pkg::SYNC_CTRL && tpos >= 0) begin
            for (int n = 0; n < 8; n++) begin
                if (n == tpos) begin
                    lanes[8*n +: 8] = rx_pcs_pkg::RS_TERM;
                end else if (n > tpos) begin
                    lanes[8*n +: 8] = rx_pcs_pkg::RS_IDLE;
                end else if (n != 3 || tpos <= 3) begin
                    // data sits one byte above its lane
                    ctl[n] = 1'b0;
                    lanes[8*n +: 8] = pl[8*n + 8 +: 8];
                end
                // lane 3 of T4..T7 only arrives with word two, so it decodes as error
            end
        end
        return {ctl, lanes};
    endfunction

    // kind 0 idle/error control, 1 start, 2 terminate at lane p, 3 unsupported type
    function automatic logic [63:0] ctrl_payload(input int kind, input int p);
        logic [63:0] pl;
        pl = rand_bits(64);
        case (kind)
            0: begin
                pl[7:0] = rx_pcs_pkg::BT_CTRL;
                for (int n = 0; n < 8; n++) begin
                    // mostly idle, now and then an error code
                    pl[8 + 7*n +: 7] = (rand_bits(3) == 0) ? rx_pcs_pkg::PCS_ERROR
                        : rx_pcs_pkg::PCS_IDLE;
                end
            end
            1: pl[7:0] = rx_pcs_pkg::BT_START;
            2: begin
                // idle codes after the terminate are all zero
                pl = '0;
                pl[7:0] = TERM_TYPES[p];
                for (int n = 0; n < p; n++) begin
                    pl[8*n + 8 +: 8] = 8'(rand_bits(8));
                end
            end
            default: pl[7:0] = BAD_TYPES[int'(rand_bits(2))];
        endcase
        return pl;
    endfunction

    function automatic logic [1:0] bad_hdr();
        return rand_bits(1) != 0 ? 2'b11 : 2'b00;
    endfunction

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge xver_rx_clk);
            i_xver_rx = '0;
        end
    endtask

    task automatic drive_word(input logic [31:0] d, input logic [1:0] hdr, input logic first);
        // zero to three gap cycles ahead of each word
        idle(int'(rand_bits(2)));
        @(negedge xver_rx_clk);
        i_xver_rx.data = d;
        i_xver_rx.header = hdr;
        i_xver_rx.data_valid = 1'b1;
        i_xver_rx.header_valid = first;
    endtask

    // queue both expected words, then send the block scrambled
    task automatic send_block(input logic [1:0] hdr, input logic [63:0] pl);
        logic [71:0] r;
        exp_word_t e;
        int tpos;
        r = ref_decode(hdr, pl);
        // terminate lane comes from the block type alone
        tpos = (hdr == rx_pcs_pkg::SYNC_CTRL) ? term_lane(pl[7:0]) : -1;
        for (int h = 0; h < 2; h++) begin
            e.data = r[32*h +: 32];
            e.ctl = r[64 + 4*h +: 4];
            e.term = '0;
            if (tpos >= 4*h && tpos < 4*h + 4) begin
                e.term[tpos - 4*h] = 1'b1;
            end
            exp_q.push_back(e);
        end
        drive_word(scramble(pl[31:0]), hdr, 1'b1);
        drive_word(scramble(pl[63:32]), hdr, 1'b0);
        hdr_count++;
    endtask

    // good blocks until the next header opens a fresh lock window
    task automatic pad_window();
        while (((hdr_count - lock_at) % rx_pcs_pkg::LOCK_WINDOW) != 0) begin
            send_block(rx_pcs_pkg::SYNC_CTRL, ctrl_payload(0, 0));
        end
    endtask

    task automatic check_lock(input logic exp_lock, input int exp_slips, input string what);
        // slip and lock settle one cycle after a header
        idle(2);
        assert (o_block_lock == exp_lock) else begin
            errors++;
            $display("[FAIL] o_block_lock %s got %h expected %h", what, o_block_lock, exp_lock);
        end
        assert (slips == exp_slips) else begin
            errors++;
            $display("[FAIL] o_xver_rx_gearbox_slip pulses %s got %h expected %h",
                what, slips, exp_slips);
        end
    endtask

    always @(negedge xver_rx_clk) begin
        if (!rx_reset && o_xver_rx_gearbox_slip) begin
            slips++;
        end
    end

    // every valid output word against the head of the queue
    always @(negedge xver_rx_clk) begin
        exp_word_t e;
        if (!rx_reset && o_xgmii_rx.valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("a decoded word came out with no expected word left");
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                checked++;
                assert (o_xgmii_rx.data == e.data) else begin
                    errors++;
                    $display("[FAIL] o_xgmii_rx.data got %h expected %h", o_xgmii_rx.data, e.data);
                end
                assert (o_xgmii_rx.ctl == e.ctl) else begin
                    errors++;
                    $display("[FAIL] o_xgmii_rx.ctl got %h expected %h", o_xgmii_rx.ctl, e.ctl);
                end
                assert (o_term_loc == e.term) else begin
                    errors++;
                    $display("[FAIL] o_term_loc got %h expected %h", o_term_loc, e.term);
                end
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge xver_rx_clk);
            cycles++;
        end
        $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("%0d words checked, %0d errors", checked, errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        i_xver_rx = '0;
        rx_reset = 1'b1;
        lfsr_state = 32'd77275;
        // scrambler starts away from the descrambler's zero state
        scr_state = 58'(rand_bits(58));
        repeat (16) @(posedge xver_rx_clk);
        @(negedge xver_rx_clk);
        rx_reset = 1'b0;

        // hunt, first bad header slips and the next four are ignored
        // these three bad blocks also fill the descrambler history
        repeat (3) send_block(bad_hdr(), rand_bits(64));
        repeat (2) send_block(rx_pcs_pkg::SYNC_DATA, rand_bits(64));
        check_lock(1'b0, 1, "inside slip hold-off");
        send_block(bad_hdr(), rand_bits(64));
        check_lock(1'b0, 2, "after second slip");
        repeat (rx_pcs_pkg::SLIP_WAIT + rx_pcs_pkg::LOCK_GOOD_COUNT - 1) begin
            send_block(rx_pcs_pkg::SYNC_DATA, rand_bits(64));
        end
        check_lock(1'b0, 2, "one header short of lock");
        send_block(rx_pcs_pkg::SYNC_DATA, rand_bits(64));
        lock_at = hdr_count;
        check_lock(1'b1, 2, "after good headers");

        // frames cycling through all terminate lanes, with single faulty blocks
        for (int f = 0; f < N_FRAMES; f++) begin
            send_block(rx_pcs_pkg::SYNC_CTRL, ctrl_payload(0, 0));
            send_block(rx_pcs_pkg::SYNC_CTRL, ctrl_payload(1, 0));
            repeat (rand_bits(2)) send_block(rx_pcs_pkg::SYNC_DATA, rand_bits(64));
            send_block(rx_pcs_pkg::SYNC_CTRL, ctrl_payload(2, f % 8));
            if (f % 6 == 3) begin
                send_block(bad_hdr(), rand_bits(64));
            end
            if (f % 6 == 5) begin
                send_block(rx_pcs_pkg::SYNC_CTRL, ctrl_payload(3, 0));
            end
        end
        check_lock(1'b1, 2, "after isolated bad blocks");

        // one under the limit in a window holds lock, the limit drops it
        pad_window();
        repeat (rx_pcs_pkg::LOCK_BAD_LIMIT - 1) send_block(bad_hdr(), rand_bits(64));
        pad_window();
        check_lock(1'b1, 2, "below bad header limit");
        repeat (rx_pcs_pkg::LOCK_BAD_LIMIT) send_block(bad_hdr(), rand_bits(64));
        check_lock(1'b0, 3, "at bad header limit");

        while (exp_q.size() != 0) begin
            @(negedge xver_rx_clk);
        end
        idle(4);
        $display("%0d words checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rx_pcs.f
rx_pcs_pkg.sv
block_lock.sv
descrambler.sv
decode_6466b.sv
rx_pcs.sv
rx_pcs_props.sv
rx_pcs_tb.sv

//--- Makefile
# verilator build and run of the rx pcs testbench

SIM = obj_dir/rx_pcs_sim

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module rx_pcs_tb -f rx_pcs.f -o rx_pcs_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
